//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_msx_slots
FILELIST  ?= msx_slots.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- block_ram.sv
`timescale 1ns/1ps
`default_nettype none

module block_ram (
   input  logic                reset,
   input  msx_pkg::mem_addr_t  addr,
   input  msx_pkg::byte_t      din,
   input  logic                we,
   output msx_pkg::byte_t      q
);

   localparam int DEPTH = 2 ** msx_pkg::RAM_ADDR_WIDTH;

   msx_pkg::byte_t mem [DEPTH];

   // Power-up contents zero
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge reset) begin
      if (we) begin
         mem[addr] <= din;
      end
      q <= mem[addr];   // Old data on a write cycle
   end

endmodule

`default_nettype wire

//--- msx2_ram_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module msx2_ram_mapper (
   input  logic                  reset,
   input  logic                  clk,
   input  msx_pkg::cpu_bus_t     bus,
   output msx_pkg::byte_t [3:0]  bank,
   output logic                  port_hit
);

   msx_pkg::byte_t [3:0] bank_reg;
   logic                 port_sel;
   logic                 port_wr;

   // Ports FC..FF decoded from the low address byte
   assign port_sel = bus.iorq && (bus.addr[7:2] == msx_pkg::MAPPER_PORT_BASE[7:2]);
   assign port_wr  = port_sel && bus.wr;
   assign port_hit = port_sel && bus.rd;

   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         // Page p starts on bank 3-p
         bank_reg <= {8'd0, 8'd1, 8'd2, 8'd3};
      end else begin
         if (port_wr) begin
            bank_reg[bus.addr[1:0]] <= bus.dout;   // Full byte kept
         end
      end
   end

   assign bank = bank_reg;

endmodule

`default_nettype wire

//--- msx_pkg.sv
`default_nettype none

package msx_pkg;

   localparam int RAM_ADDR_WIDTH = 18;

   typedef logic [15:0] cpu_addr_t;
   typedef logic [7:0]  byte_t;
   typedef logic [3:0]  block_t;                    // 16 KB block index
   typedef logic [RAM_ADDR_WIDTH-1:0] mem_addr_t;   // Block followed by 14 offset bits

   typedef enum logic [1:0] {
      SLOT_EMPTY,
      SLOT_RAM,
      SLOT_MAPPER_RAM,
      SLOT_EXPANDED
   } slot_typ_t;

   typedef enum logic {
      PAGE_EMPTY,
      PAGE_RAM
   } page_typ_t;

   typedef enum logic [1:0] {
      SRC_NONE,
      SRC_RAM,
      SRC_SUBSLOT,
      SRC_MAPPER
   } read_src_t;

   typedef struct packed {
      slot_typ_t typ;
      block_t    base;
   } slot_cfg_t;

   typedef struct packed {
      page_typ_t typ;
      block_t    block;
   } page_cfg_t;

   // Indexed [slot][subslot][page]
   typedef struct packed {
      slot_cfg_t [3:0]             slot;
      page_cfg_t [3:0][3:0][3:0]   sub_page;
   } slots_cfg_t;

   typedef struct packed {
      cpu_addr_t addr;
      byte_t     dout;
      logic      rd;
      logic      wr;
      logic      mreq;
      logic      iorq;
   } cpu_bus_t;

   localparam cpu_addr_t SUBSLOT_REG_ADDR = 16'hFFFF;
   localparam byte_t     MAPPER_PORT_BASE = 8'hFC;
   localparam byte_t     MAPPER_MASK      = 8'h07;   // 128 KB of mapper RAM
   localparam byte_t     OPEN_BUS         = 8'hFF;

endpackage

`default_nettype wire

//--- msx_slots.f
msx_pkg.sv
subslot_regs.sv
msx2_ram_mapper.sv
slot_decoder.sv
block_ram.sv
msx_slots.sv
msx_slots_checker.sv
tb_msx_slots.sv

//--- msx_slots.sv
`timescale 1ns/1ps
`default_nettype none

module msx_slots (
   input  logic                 reset,
   input  logic                 clk,
   input  msx_pkg::cpu_bus_t    bus,
   input  msx_pkg::slots_cfg_t  cfg,
   input  logic [1:0]           active_slot,
   output msx_pkg::byte_t       cpu_din
);

   msx_pkg::byte_t [3:0]  sub_sel;
   msx_pkg::byte_t [3:0]  bank;
   logic                  mapper_hit;
   msx_pkg::mem_addr_t    ram_addr;
   logic                  ram_we;
   logic                  sub_wr;
   msx_pkg::read_src_t    read_src;
   msx_pkg::byte_t        ram_q;

   logic                  rd_sampled;
   msx_pkg::byte_t        readback;
   logic                  rd_valid;
   msx_pkg::read_src_t    src_q;
   msx_pkg::byte_t        readback_q;
   msx_pkg::byte_t        din_hold;
   msx_pkg::byte_t        read_data;

   subslot_regs u_subslot_regs (
      .reset       (reset),
      .clk         (clk),
      .sub_wr      (sub_wr),
      .active_slot (active_slot),
      .din         (bus.dout),
      .sub_sel     (sub_sel)
   );

   msx2_ram_mapper u_msx2_ram_mapper (
      .reset    (reset),
      .clk      (clk),
      .bus      (bus),
      .bank     (bank),
      .port_hit (mapper_hit)
   );

   slot_decoder u_slot_decoder (
      .bus         (bus),
      .cfg         (cfg),
      .active_slot (active_slot),
      .sub_sel     (sub_sel),
      .bank        (bank),
      .mapper_hit  (mapper_hit),
      .ram_addr    (ram_addr),
      .ram_we      (ram_we),
      .sub_wr      (sub_wr),
      .read_src    (read_src)
   );

   block_ram u_block_ram (
      .reset (reset),
      .addr  (ram_addr),
      .din   (bus.dout),
      .we    (ram_we),
      .q     (ram_q)
   );

   assign rd_sampled = bus.rd && (bus.mreq || bus.iorq);

   // Subslot reads back inverted, mapper sets the bits above the mask
   assign readback = (read_src == msx_pkg::SRC_SUBSLOT) ?
                     ~sub_sel[active_slot] :
                     (bank[bus.addr[1:0]] | ~msx_pkg::MAPPER_MASK);

   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         rd_valid <= 1'b0;
         src_q    <= msx_pkg::SRC_NONE;
         din_hold <= msx_pkg::OPEN_BUS;
      end else begin
         rd_valid <= rd_sampled;
         din_hold <= cpu_din;   // Keeps the last result between reads
         if (rd_sampled) begin
            src_q <= read_src;
         end
      end
   end

   always_ff @(posedge reset) begin
      if (rd_sampled) begin
         readback_q <= readback;
      end
   end

   // Lines up with the RAM output of the same read
   always_comb begin
      case (src_q)
         msx_pkg::SRC_RAM:     read_data = ram_q;
         msx_pkg::SRC_SUBSLOT: read_data = readback_q;
         msx_pkg::SRC_MAPPER:  read_data = readback_q;
         default:              read_data = msx_pkg::OPEN_BUS;
      endcase
   end

   assign cpu_din = rd_valid ? read_data : din_hold;

endmodule

`default_nettype wire

//--- msx_slots_checker.sv
`timescale 1ns/1ps
`default_nettype none

module msx_slots_checker (
   input logic               reset,
   input logic               clk,
   input msx_pkg::cpu_bus_t  bus,
   input msx_pkg::byte_t     cpu_din
);

   logic        rd_sampled;
   int unsigned fail_cnt = 0;   // Failed assertions so far

   assign rd_sampled = bus.rd && (bus.mreq || bus.iorq);

   // Output moves only on the edge that samples a read
   din_stable: assert property (@(posedge reset) disable iff (clk)
      !$past(rd_sampled) |-> $stable(cpu_din))
      else begin
         fail_cnt++;
         $error("cpu_din changed without a sampled read");
      end

   din_after_reset: assert property (@(posedge reset)
      $fell(clk) |-> cpu_din == msx_pkg::OPEN_BUS)
      else begin
         fail_cnt++;
         $error("cpu_din is not open bus after reset");
      end

   din_known: assert property (@(posedge reset) disable iff (clk) !$isunknown(cpu_din))
      else begin
         fail_cnt++;
         $error("cpu_din has unknown bits");
      end

endmodule

`default_nettype wire

//--- slot_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module slot_decoder (
   input  msx_pkg::cpu_bus_t     bus,
   input  msx_pkg::slots_cfg_t   cfg,
   input  logic [1:0]            active_slot,
   input  msx_pkg::byte_t [3:0]  sub_sel,
   input  msx_pkg::byte_t [3:0]  bank,
   input  logic                  mapper_hit,
   output msx_pkg::mem_addr_t    ram_addr,
   output logic                  ram_we,
   output logic                  sub_wr,
   output msx_pkg::read_src_t    read_src
);

   logic [1:0]          page;
   logic [1:0]          subslot;
   msx_pkg::slot_cfg_t  slot_cfg;
   msx_pkg::page_cfg_t  sub_cfg;
   msx_pkg::byte_t      slot_sub;
   msx_pkg::byte_t      bank_masked;
   msx_pkg::block_t     blk;
   logic                mapped;
   logic                sub_access;
   logic                mem_sel;

   assign page     = bus.addr[15:14];
   assign slot_cfg = cfg.slot[active_slot];
   assign slot_sub = sub_sel[active_slot];
   assign subslot  = slot_sub[2*page +: 2];
   assign sub_cfg  = cfg.sub_page[active_slot][subslot][page];

   assign bank_masked = bank[page] & msx_pkg::MAPPER_MASK;

   // FFFF of an expanded slot is the subslot register, never RAM
   assign sub_access = bus.mreq && (slot_cfg.typ == msx_pkg::SLOT_EXPANDED) &&
                       (bus.addr == msx_pkg::SUBSLOT_REG_ADDR);

   always_comb begin
      mapped = 1'b0;
      blk    = '0;
      case (slot_cfg.typ)
         msx_pkg::SLOT_RAM: begin
            mapped = 1'b1;
            blk    = slot_cfg.base + msx_pkg::block_t'(page);   // Wraps in 4 bits
         end
         msx_pkg::SLOT_MAPPER_RAM: begin
            mapped = 1'b1;
            blk    = slot_cfg.base + bank_masked[3:0];
         end
         msx_pkg::SLOT_EXPANDED: begin
            mapped = (sub_cfg.typ == msx_pkg::PAGE_RAM);
            blk    = sub_cfg.block;
         end
         default: begin
            mapped = 1'b0;   // Empty slot
            blk    = '0;
         end
      endcase
   end

   assign mem_sel  = bus.mreq && mapped && !sub_access;
   assign ram_addr = {blk, bus.addr[13:0]};
   assign ram_we   = mem_sel && bus.wr;
   assign sub_wr   = sub_access && bus.wr;

   always_comb begin
      if (mapper_hit) begin
         read_src = msx_pkg::SRC_MAPPER;
      end else if (sub_access) begin
         read_src = msx_pkg::SRC_SUBSLOT;
      end else if (mem_sel) begin
         read_src = msx_pkg::SRC_RAM;
      end else begin
         read_src = msx_pkg::SRC_NONE;
      end
   end

endmodule

`default_nettype wire

//--- subslot_regs.sv
`timescale 1ns/1ps
`default_nettype none

module subslot_regs (
   input  logic                  reset,
   input  logic                  clk,
   input  logic                  sub_wr,
   input  logic [1:0]            active_slot,
   input  msx_pkg::byte_t        din,
   output msx_pkg::byte_t [3:0]  sub_sel
);

   // One secondary slot byte per primary slot
   msx_pkg::byte_t [3:0] sub_reg;

   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         sub_reg <= '0;
      end else begin
         if (sub_wr) begin
            sub_reg[active_slot] <= din;   // Two bits per page
         end
      end
   end

   assign sub_sel = sub_reg;

endmodule

`default_nettype wire

//--- tb_msx_slots.sv
`timescale 1ns/1ps
`default_nettype none

module tb_msx_slots;

   logic                 reset;   // Clock
   logic                 clk;     // Reset, active high
   msx_pkg::cpu_bus_t    bus;
   msx_pkg::slots_cfg_t  cfg;
   logic [1:0]           active_slot;
   msx_pkg::byte_t       cpu_din;

   msx_pkg::byte_t       ram_sh[msx_pkg::mem_addr_t];
   msx_pkg::byte_t       sub_sh[4];
   msx_pkg::byte_t       bank_sh[4];
   logic [8:0]           exp_q[$];   // Known flag, then byte
   logic [8:0]           entry;
   logic [31:0]          seed = 32'd11301;
   msx_pkg::cpu_addr_t   addr_list[32];

   msx_slots u_msx_slots (
      .reset       (reset),
      .clk         (clk),
      .bus         (bus),
      .cfg         (cfg),
      .active_slot (active_slot),
      .cpu_din     (cpu_din)
   );

   bind msx_slots msx_slots_checker u_msx_slots_checker (
      .reset   (reset),
      .clk     (clk),
      .bus     (bus),
      .cpu_din (cpu_din)
   );

   initial begin
      reset = 1'b0;
      forever #10 reset = ~reset;
   end

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed >> 8;   // Low LCG bits are weak
   endfunction

   // Hit flag, block and offset for a memory access
   function automatic logic [18:0] ram_target(msx_pkg::cpu_bus_t b, logic [1:0] s);
      logic [1:0]          p;
      msx_pkg::page_cfg_t  pc;
      msx_pkg::block_t     blk;
      logic                hit;
      p = b.addr[15:14];
      pc = cfg.sub_page[s][sub_sh[s][2*p +: 2]][p];
      hit = 1'b1;
      blk = '0;
      case (cfg.slot[s].typ)
         msx_pkg::SLOT_RAM:        blk = cfg.slot[s].base + msx_pkg::block_t'(p);
         msx_pkg::SLOT_MAPPER_RAM: blk = cfg.slot[s].base +
                                         msx_pkg::block_t'(bank_sh[p] & msx_pkg::MAPPER_MASK);
         msx_pkg::SLOT_EXPANDED: begin
            hit = (b.addr != msx_pkg::SUBSLOT_REG_ADDR) && (pc.typ == msx_pkg::PAGE_RAM);
            blk = pc.block;
         end
         default:                  hit = 1'b0;
      endcase
      return {hit, blk, b.addr[13:0]};
   endfunction

   function automatic logic [8:0] expected_read(msx_pkg::cpu_bus_t b, logic [1:0] s);
      logic [18:0] t;
      t = ram_target(b, s);
      if (b.iorq) begin
         if (b.addr[7:2] == msx_pkg::MAPPER_PORT_BASE[7:2])
            return {1'b1, bank_sh[b.addr[1:0]] | ~msx_pkg::MAPPER_MASK};
         return {1'b1, msx_pkg::OPEN_BUS};
      end
      if (cfg.slot[s].typ == msx_pkg::SLOT_EXPANDED && b.addr == msx_pkg::SUBSLOT_REG_ADDR)
         return {1'b1, ~sub_sh[s]};
      if (!t[18])
         return {1'b1, msx_pkg::OPEN_BUS};
      if (!ram_sh.exists(t[17:0]))
         return {1'b0, 8'h00};   // Never written so not checked
      return {1'b1, ram_sh[t[17:0]]};
   endfunction

   function automatic void model_write(msx_pkg::cpu_bus_t b, logic [1:0] s);
      logic [18:0] t;
      t = ram_target(b, s);
      if (b.iorq && b.addr[7:2] == msx_pkg::MAPPER_PORT_BASE[7:2])
         bank_sh[b.addr[1:0]] = b.dout;
      else if (b.mreq && cfg.slot[s].typ == msx_pkg::SLOT_EXPANDED &&
               b.addr == msx_pkg::SUBSLOT_REG_ADDR)
         sub_sh[s] = b.dout;
      else if (b.mreq && t[18])
         ram_sh[t[17:0]] = b.dout;
   endfunction

   task automatic drive(input msx_pkg::cpu_bus_t b, input logic [1:0] s);
      @(posedge reset);
      #2;
      if (b.rd && (b.mreq || b.iorq))
         exp_q.push_back(expected_read(b, s));
      if (b.wr)
         model_write(b, s);
      bus = b;
      active_slot = s;
   endtask

   task automatic mem_write(input logic [1:0] s, input msx_pkg::cpu_addr_t a,
                            input msx_pkg::byte_t d);
      drive('{addr: a, dout: d, rd: 1'b0, wr: 1'b1, mreq: 1'b1, iorq: 1'b0}, s);
   endtask

   task automatic mem_read(input logic [1:0] s, input msx_pkg::cpu_addr_t a);
      drive('{addr: a, dout: 8'h00, rd: 1'b1, wr: 1'b0, mreq: 1'b1, iorq: 1'b0}, s);
   endtask

   task automatic io_write(input msx_pkg::byte_t port, input msx_pkg::byte_t d);
      drive('{addr: {8'h00, port}, dout: d, rd: 1'b0, wr: 1'b1, mreq: 1'b0, iorq: 1'b1}, 2'd0);
   endtask

   task automatic io_read(input msx_pkg::byte_t port);
      drive('{addr: {8'h00, port}, dout: 8'h00, rd: 1'b1, wr: 1'b0, mreq: 1'b0, iorq: 1'b1},
            2'd0);
   endtask

   // One edge after each sampled read
   always @(posedge reset) begin
      if (!clk && bus.rd && (bus.mreq || bus.iorq)) begin
         #1;
         if (exp_q.size() == 0) begin
            $display("A read was sampled with no expected value queued at %0t", $time);
            $display(">>> FAIL");
            $fatal(1, "Compare queue underflow");
         end else begin
            entry = exp_q.pop_front();
            if (entry[8]) begin
               assert (cpu_din === entry[7:0]) else begin
                  $display("FAIL %0t: slot %0d addr %h iorq %b read %h, expected %h", $time,
                           active_slot, bus.addr, bus.iorq, cpu_din, entry[7:0]);
                  $display(">>> FAIL");
                  $fatal(1, "Read data mismatch");
               end
            end
         end
      end
   end

   initial begin
      int i;
      int p;
      int wait_cnt;
      logic [31:0] r;
      msx_pkg::byte_t tmp;
      msx_pkg::byte_t sel_list[3];
      clk = 1'b1;
      bus = '0;
      active_slot = 2'd0;
      cfg = '0;
      cfg.slot[0] = '{typ: msx_pkg::SLOT_RAM, base: 4'd14};
      cfg.slot[1] = '{typ: msx_pkg::SLOT_EXPANDED, base: 4'd0};
      cfg.slot[2] = '{typ: msx_pkg::SLOT_MAPPER_RAM, base: 4'd8};
      cfg.slot[3] = '{typ: msx_pkg::SLOT_EMPTY, base: 4'd0};
      for (p = 0; p < 4; p++) begin
         cfg.sub_page[1][0][p] = '{typ: msx_pkg::PAGE_RAM, block: msx_pkg::block_t'(4 + p)};
         cfg.sub_page[1][1][p] = '{typ: msx_pkg::PAGE_RAM,
                                   block: msx_pkg::block_t'(4 + (p + 1) % 4)};
         cfg.sub_page[1][2][p] = '{typ: msx_pkg::PAGE_RAM, block: msx_pkg::block_t'(14 + p)};
         cfg.sub_page[1][3][p] = '{typ: msx_pkg::PAGE_EMPTY, block: msx_pkg::block_t'(14 + p)};
         sub_sh[p] = 8'h00;
         bank_sh[p] = msx_pkg::byte_t'(3 - p);
      end
      repeat (16) @(posedge reset);
      #2;
      clk = 1'b0;

      // Reset values
      mem_read(2'd1, msx_pkg::SUBSLOT_REG_ADDR);
      for (p = 0; p < 4; p++)
         io_read(msx_pkg::MAPPER_PORT_BASE + msx_pkg::byte_t'(p));
      mem_read(2'd3, 16'h4000);
      io_read(8'h20);

      // Plain RAM slot with page p on block base+p mod 16
      for (i = 0; i < 32; i++) begin
         r = next_rand();
         addr_list[i] = {2'(i), 8'h00, r[5:0]};
         mem_write(2'd0, addr_list[i], r[15:8]);
      end
      for (i = 0; i < 32; i++)
         mem_read(2'd0, addr_list[i]);

      // Expanded slot
      mem_write(2'd1, msx_pkg::SUBSLOT_REG_ADDR, 8'h00);
      mem_read(2'd1, msx_pkg::SUBSLOT_REG_ADDR);
      for (p = 0; p < 4; p++) begin
         r = next_rand();
         mem_write(2'd1, {2'(p), 14'h0123}, r[7:0]);
      end
      sel_list = '{8'h55, 8'hAA, 8'hE4};
      for (i = 0; i < 3; i++) begin
         mem_write(2'd1, msx_pkg::SUBSLOT_REG_ADDR, sel_list[i]);
         mem_read(2'd1, msx_pkg::SUBSLOT_REG_ADDR);
         for (p = 0; p < 4; p++)
            mem_read(2'd1, {2'(p), 14'h0123});
      end
      mem_write(2'd1, msx_pkg::SUBSLOT_REG_ADDR, 8'hAA);
      for (p = 0; p < 4; p++) begin
         r = next_rand();
         mem_write(2'd1, {2'(p), 14'h0321}, r[7:0]);
         mem_read(2'd0, {2'(p), 14'h0321});
      end

      // Mapper banks and aliases under the mask
      for (p = 0; p < 4; p++) begin
         r = next_rand();
         io_write(msx_pkg::MAPPER_PORT_BASE + msx_pkg::byte_t'(p), r[7:0]);
         io_read(msx_pkg::MAPPER_PORT_BASE + msx_pkg::byte_t'(p));
         mem_write(2'd2, {2'(p), 14'h0200}, r[15:8]);
      end
      tmp = bank_sh[0];
      for (p = 0; p < 4; p++) begin
         io_write(msx_pkg::MAPPER_PORT_BASE + msx_pkg::byte_t'(p),
                  tmp ^ (msx_pkg::byte_t'(p) << 3));
         io_read(msx_pkg::MAPPER_PORT_BASE + msx_pkg::byte_t'(p));
         mem_read(2'd2, {2'(p), 14'h0200});
      end

      // Empty slot and empty pages drop writes
      mem_write(2'd1, msx_pkg::SUBSLOT_REG_ADDR, 8'hFF);
      for (i = 0; i < 8; i++) begin
         r = next_rand();
         mem_write(2'd3, addr_list[i], r[7:0]);
         mem_write(2'd1, addr_list[i], r[15:8]);
         mem_read(2'd1, addr_list[i]);
      end
      for (i = 0; i < 8; i++)
         mem_read(2'd0, addr_list[i]);

      // Random mix
      for (i = 0; i < 600; i++) begin
         r = next_rand();
         case (r[4:2])
            3'd0, 3'd1:       mem_write(r[1:0], {r[9:8], 8'h00, r[15:10]}, r[23:16]);
            3'd2, 3'd3, 3'd4: mem_read(r[1:0], {r[9:8], 8'h00, r[15:10]});
            3'd5:             io_write({msx_pkg::MAPPER_PORT_BASE[7:2], r[6:5]}, r[23:16]);
            3'd6:             io_read(r[7] ? {msx_pkg::MAPPER_PORT_BASE[7:2], r[6:5]} : r[23:16]);
            default: begin
               if (r[5])
                  mem_write(2'd1, msx_pkg::SUBSLOT_REG_ADDR, r[23:16]);
               else
                  mem_read(r[1:0], msx_pkg::SUBSLOT_REG_ADDR);
            end
         endcase
      end
      drive('0, 2'd0);

      wait_cnt = 0;
      while (exp_q.size() != 0 && wait_cnt < 20) begin
         @(posedge reset);
         wait_cnt++;
      end
      #5;
      if (exp_q.size() != 0) begin
         $display("Timed out waiting for %0d outstanding reads to be compared", exp_q.size());
         $display(">>> FAIL");
         $fatal(1, "Compare stalled");
      end else if (u_msx_slots.u_msx_slots_checker.fail_cnt != 0) begin
         $display("%0d assertions of the bound checker failed",
                  u_msx_slots.u_msx_slots_checker.fail_cnt);
         $display(">>> FAIL");
         $fatal(1, "Checker assertions failed");
      end else begin
         $display(">>> PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire
